// ==== verilog/vga_timing_pkg.sv ====
// Video mode constants and counter types for the small simulation VGA mode
package vga_timing_pkg;

  // Horizontal periods in pixels with the visible region last
  localparam int H_FRONT   = 2;
  localparam int H_SYNC    = 4;
  localparam int H_BACK    = 2;
  localparam int H_VISIBLE = 16;
  localparam int H_TOTAL   = H_FRONT + H_SYNC + H_BACK + H_VISIBLE;

  // Vertical periods in lines with the visible region last
  localparam int V_FRONT   = 1;
  localparam int V_SYNC    = 2;
  localparam int V_BACK    = 1;
  localparam int V_VISIBLE = 8;
  localparam int V_TOTAL   = V_FRONT + V_SYNC + V_BACK + V_VISIBLE;

  // Window starts within each counter range
  localparam int H_SYNC_START = H_FRONT;
  localparam int H_VIS_START  = H_FRONT + H_SYNC + H_BACK;
  localparam int V_SYNC_START = V_FRONT;
  localparam int V_VIS_START  = V_FRONT + V_SYNC + V_BACK;

  // Sync pulses are active low

  typedef logic [7:0] h_count_t;
  typedef logic [7:0] v_count_t;

endpackage

// ==== verilog/gfx_pkg.sv ====
// Pixel, colour, pattern and flow control types for the test-pattern path
package gfx_pkg;

  typedef logic [3:0]  color_t;
  typedef logic [11:0] pixel_t;        // {red, green, blue}

  typedef enum logic [1:0] {
    PAT_BARS,
    PAT_CHECKER,
    PAT_GRADIENT
  } pattern_e;

  localparam int FIFO_DEPTH  = 8;
  localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

  typedef logic [3:0]  credit_t;       // Holds 0..FIFO_DEPTH
  typedef logic [15:0] error_count_t;

  // Pattern rules for visible column x and row y:
  //   PAT_BARS     bar = x / 2 (8 bars); red, green, blue are all ones
  //                when bar bit 2, 1, 0 is set, zero otherwise
  //   PAT_CHECKER  white when x[1] != y[1], black otherwise
  //   PAT_GRADIENT red = x[3:0], green = y[3:0], blue = (x + y)[3:0]

endpackage

// ==== verilog/gfx_pattern_gen.sv ====
// Raster-order test pattern generator pushing pixels under credit flow control
`timescale 1ns/1ps

module gfx_pattern_gen (
  input  logic              pixel_clk,
  input  logic              rst_n,
  input  logic              continuous_write,
  input  gfx_pkg::pattern_e pattern_sel,
  input  logic              credit_return,
  output logic              pixel_push,
  output gfx_pkg::pixel_t   pixel_data
);
  import gfx_pkg::*;
  import vga_timing_pkg::*;

  h_count_t x;
  v_count_t y;
  credit_t  credits;
  pattern_e frame_pattern;
  pattern_e cur_pattern;
  logic     frame_start;

  function automatic pixel_t pattern_pixel(input pattern_e pat, input h_count_t px,
                                           input v_count_t py);
    logic [2:0] bar;
    logic [7:0] sum;
    bar = px[3:1];
    sum = px + py;
    case (pat)
      PAT_BARS:     pattern_pixel = {{4{bar[2]}}, {4{bar[1]}}, {4{bar[0]}}};
      PAT_CHECKER:  pattern_pixel = (px[1] ^ py[1]) ? '1 : '0;
      PAT_GRADIENT: pattern_pixel = {px[3:0], py[3:0], sum[3:0]};
      default:      pattern_pixel = '0;
    endcase
  endfunction

  assign frame_start = (x == '0) && (y == '0);
  // First pixel of a frame takes the live selection
  assign cur_pattern = frame_start ? pattern_sel : frame_pattern;

  assign pixel_push = continuous_write && (credits != '0);
  assign pixel_data = pattern_pixel(cur_pattern, x, y);

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      credits <= credit_t'(FIFO_DEPTH);
    end else begin
      credits <= credits + credit_t'(credit_return) - credit_t'(pixel_push);
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      x             <= '0;
      y             <= '0;
      frame_pattern <= PAT_BARS;
    end else if (pixel_push) begin
      if (frame_start) frame_pattern <= pattern_sel;  // Held for the whole frame
      if (x == h_count_t'(H_VISIBLE - 1)) begin
        x <= '0;
        if (y == v_count_t'(V_VISIBLE - 1)) begin
          y <= '0;
        end else begin
          y <= y + 1'b1;
        end
      end else begin
        x <= x + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/gfx_pixel_fifo.sv ====
// Small circular pixel FIFO that hands back one credit per pop
`timescale 1ns/1ps

module gfx_pixel_fifo (
  input  logic            pixel_clk,
  input  logic            rst_n,
  input  logic            pixel_push,
  input  gfx_pkg::pixel_t pixel_data,
  input  logic            pixel_pop,
  output gfx_pkg::pixel_t head_pixel,
  output logic            fifo_empty,
  output logic            credit_return
);
  import gfx_pkg::*;

  pixel_t                 mem [FIFO_DEPTH];
  logic [FIFO_ADDR_W-1:0] wr_ptr;
  logic [FIFO_ADDR_W-1:0] rd_ptr;
  credit_t                count;

  // Depth is a power of two so the pointers wrap on their own
  always_ff @(posedge pixel_clk) begin
    if (pixel_push) mem[wr_ptr] <= pixel_data;
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (pixel_push) wr_ptr <= wr_ptr + 1'b1;
      if (pixel_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({pixel_push, pixel_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      credit_return <= pixel_pop;  // Credit back one cycle after the pop
    end
  end

  assign head_pixel = mem[rd_ptr];
  assign fifo_empty = (count == '0);

endmodule

// ==== verilog/vga_timing.sv ====
// Free-running VGA raster counters with sync and visible decode
`timescale 1ns/1ps

module vga_timing (
  input  logic                     pixel_clk,
  input  logic                     rst_n,
  output vga_timing_pkg::h_count_t h_count,
  output vga_timing_pkg::v_count_t v_count,
  output logic                     hsync_raw,
  output logic                     vsync_raw,
  output logic                     visible
);
  import vga_timing_pkg::*;

  logic h_in_sync;
  logic v_in_sync;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      h_count <= '0;
      v_count <= '0;
    end else if (h_count == h_count_t'(H_TOTAL - 1)) begin
      h_count <= '0;
      if (v_count == v_count_t'(V_TOTAL - 1)) begin
        v_count <= '0;
      end else begin
        v_count <= v_count + 1'b1;
      end
    end else begin
      h_count <= h_count + 1'b1;
    end
  end

  assign h_in_sync = (h_count >= h_count_t'(H_SYNC_START)) &&
                     (h_count < h_count_t'(H_SYNC_START + H_SYNC));
  assign v_in_sync = (v_count >= v_count_t'(V_SYNC_START)) &&
                     (v_count < v_count_t'(V_SYNC_START + V_SYNC));

  // Active low pulses
  assign hsync_raw = !h_in_sync;
  assign vsync_raw = !v_in_sync;

  // Visible window runs to the end of both ranges
  assign visible = (h_count >= h_count_t'(H_VIS_START)) &&
                   (v_count >= v_count_t'(V_VIS_START));

endmodule

// ==== verilog/vga_pixel_out.sv ====
// VGA output stage popping the FIFO at visible positions and counting underflows
`timescale 1ns/1ps

module vga_pixel_out (
  input  logic                  pixel_clk,
  input  logic                  rst_n,
  input  logic                  visible,
  input  logic                  hsync_raw,
  input  logic                  vsync_raw,
  input  gfx_pkg::pixel_t       head_pixel,
  input  logic                  fifo_empty,
  output logic                  pixel_pop,
  output gfx_pkg::color_t       vga_red,
  output gfx_pkg::color_t       vga_grn,
  output gfx_pkg::color_t       vga_blu,
  output logic                  vga_hsync,
  output logic                  vga_vsync,
  output gfx_pkg::error_count_t error_count
);
  import gfx_pkg::*;

  logic underflow;

  assign pixel_pop = visible && !fifo_empty;
  assign underflow = visible && fifo_empty;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      vga_red     <= '0;
      vga_grn     <= '0;
      vga_blu     <= '0;
      vga_hsync   <= 1'b1;
      vga_vsync   <= 1'b1;
      error_count <= '0;
    end else begin
      vga_hsync <= hsync_raw;  // Same latency as the colours
      vga_vsync <= vsync_raw;
      if (pixel_pop) begin
        {vga_red, vga_grn, vga_blu} <= head_pixel;
      end else begin
        // Blanking or a missing pixel
        vga_red <= '0;
        vga_grn <= '0;
        vga_blu <= '0;
      end
      if (underflow && (error_count != '1)) begin
        error_count <= error_count + 1'b1;  // Saturates at all ones
      end
    end
  end

endmodule

// ==== verilog/gfx_pattern_demo_top.sv ====
// Test-pattern subsystem top tying generator, pixel FIFO, timing and output stage
`timescale 1ns/1ps

module gfx_pattern_demo_top (
  input  logic                  pixel_clk,
  input  logic                  rst_n,
  input  logic                  continuous_write,
  input  gfx_pkg::pattern_e     pattern_sel,
  output gfx_pkg::color_t       vga_red,
  output gfx_pkg::color_t       vga_grn,
  output gfx_pkg::color_t       vga_blu,
  output logic                  vga_hsync,
  output logic                  vga_vsync,
  output gfx_pkg::error_count_t error_count
);
  import gfx_pkg::*;

  logic   pixel_push;
  pixel_t pixel_data;
  logic   credit_return;
  pixel_t head_pixel;
  logic   fifo_empty;
  logic   pixel_pop;
  logic   hsync_raw;
  logic   vsync_raw;
  logic   visible;

  gfx_pattern_gen gen_i (
    .pixel_clk       (pixel_clk),
    .rst_n           (rst_n),
    .continuous_write(continuous_write),
    .pattern_sel     (pattern_sel),
    .credit_return   (credit_return),
    .pixel_push      (pixel_push),
    .pixel_data      (pixel_data)
  );

  gfx_pixel_fifo fifo_i (
    .pixel_clk    (pixel_clk),
    .rst_n        (rst_n),
    .pixel_push   (pixel_push),
    .pixel_data   (pixel_data),
    .pixel_pop    (pixel_pop),
    .head_pixel   (head_pixel),
    .fifo_empty   (fifo_empty),
    .credit_return(credit_return)
  );

  // Raster position is only needed for debug probing
  vga_timing timing_i (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .h_count  (),
    .v_count  (),
    .hsync_raw(hsync_raw),
    .vsync_raw(vsync_raw),
    .visible  (visible)
  );

  vga_pixel_out out_i (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .visible    (visible),
    .hsync_raw  (hsync_raw),
    .vsync_raw  (vsync_raw),
    .head_pixel (head_pixel),
    .fifo_empty (fifo_empty),
    .pixel_pop  (pixel_pop),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .error_count(error_count)
  );

endmodule

// ==== verif/tb_clock_gen.sv ====
// Testbench pixel clock source with a 100 ns period
`timescale 1ns/1ps

module tb_clock_gen (
  output logic pixel_clk
);

  initial pixel_clk = 1'b0;

  always begin
    #50;
    pixel_clk = ~pixel_clk;  // Half period
  end

endmodule

// ==== verif/gfx_pattern_demo_tb.sv ====
// Table-driven testbench for the VGA test-pattern subsystem with a pixel reference model
`timescale 1ns/1ps

module gfx_pattern_demo_tb;
  import gfx_pkg::*;
  import vga_timing_pkg::*;

  localparam int RESET_CYCLES  = 5;
  localparam int NUM_ROWS      = 5;
  localparam int VIS_PER_FRAME = H_VISIBLE * V_VISIBLE;

  typedef struct {
    pattern_e     pat;
    logic         cw;
    int           frames;
    error_count_t exp_errors;
  } test_row_t;

  logic         pixel_clk;
  logic         rst_n;
  logic         continuous_write;
  pattern_e     pattern_sel;
  color_t       vga_red;
  color_t       vga_grn;
  color_t       vga_blu;
  logic         vga_hsync;
  logic         vga_vsync;
  error_count_t error_count;

  test_row_t    table_rows [NUM_ROWS];
  int           tb_h;
  int           tb_v;
  error_count_t exp_err;
  error_count_t prev_err;
  int           mismatches;
  int           tests_passed;
  int           tests_failed;

  tb_clock_gen clk_i (.pixel_clk(pixel_clk));

  gfx_pattern_demo_top UUT (
    .pixel_clk       (pixel_clk),
    .rst_n           (rst_n),
    .continuous_write(continuous_write),
    .pattern_sel     (pattern_sel),
    .vga_red         (vga_red),
    .vga_grn         (vga_grn),
    .vga_blu         (vga_blu),
    .vga_hsync       (vga_hsync),
    .vga_vsync       (vga_vsync),
    .error_count     (error_count)
  );

  task automatic check_color(input string name, input color_t got, input color_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_sync(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %0b expected %0b", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_errors(input string name, input error_count_t got,
                              input error_count_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      mismatches++;
    end
  endtask

  // Expected colours for visible column x and row y
  function automatic void ref_pixel(input pattern_e pat, input int x, input int y,
                                    output color_t r, output color_t g, output color_t b);
    int bar;
    bar = x / 2;
    r = 4'h0;
    g = 4'h0;
    b = 4'h0;
    case (pat)
      PAT_BARS: begin
        r = ((bar & 4) != 0) ? 4'hF : 4'h0;
        g = ((bar & 2) != 0) ? 4'hF : 4'h0;
        b = ((bar & 1) != 0) ? 4'hF : 4'h0;
      end
      PAT_CHECKER: begin
        if (((x / 2) % 2) != ((y / 2) % 2)) begin
          r = 4'hF;
          g = 4'hF;
          b = 4'hF;
        end
      end
      PAT_GRADIENT: begin
        r = color_t'(x % 16);
        g = color_t'(y % 16);
        b = color_t'((x + y) % 16);
      end
      default: ;
    endcase
  endfunction

  task automatic apply_reset(input pattern_e pat, input logic cw);
    rst_n            = 1'b0;
    pattern_sel      = pat;
    continuous_write = cw;
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(posedge pixel_clk);
      @(negedge pixel_clk);
    end
    check_sync("vga_hsync", vga_hsync, 1'b1);
    check_sync("vga_vsync", vga_vsync, 1'b1);
    check_color("vga_red", vga_red, 4'h0);
    check_color("vga_grn", vga_grn, 4'h0);
    check_color("vga_blu", vga_blu, 4'h0);
    check_errors("error_count", error_count, '0);
    rst_n    = 1'b1;
    tb_h     = 0;  // DUT counters sit at 0,0 in the first cycle
    tb_v     = 0;
    exp_err  = '0;
    prev_err = '0;
  endtask

  // Outputs of one pixel clock compared against the position one cycle back
  task automatic run_cycle(input pattern_e pat, input logic cw);
    color_t exp_r;
    color_t exp_g;
    color_t exp_b;
    logic   exp_hs;
    logic   exp_vs;
    logic   vis;
    @(posedge pixel_clk);
    @(negedge pixel_clk);
    vis    = (tb_h >= H_FRONT + H_SYNC + H_BACK) && (tb_v >= V_FRONT + V_SYNC + V_BACK);
    exp_hs = !((tb_h >= H_FRONT) && (tb_h < H_FRONT + H_SYNC));
    exp_vs = !((tb_v >= V_FRONT) && (tb_v < V_FRONT + V_SYNC));
    exp_r  = 4'h0;
    exp_g  = 4'h0;
    exp_b  = 4'h0;
    if (vis && cw) begin
      ref_pixel(pat, tb_h - (H_FRONT + H_SYNC + H_BACK), tb_v - (V_FRONT + V_SYNC + V_BACK),
                exp_r, exp_g, exp_b);
    end
    if (vis && !cw && (exp_err != '1)) exp_err = exp_err + error_count_t'(1);
    check_sync("vga_hsync", vga_hsync, exp_hs);
    check_sync("vga_vsync", vga_vsync, exp_vs);
    check_color("vga_red", vga_red, exp_r);
    check_color("vga_grn", vga_grn, exp_g);
    check_color("vga_blu", vga_blu, exp_b);
    check_errors("error_count", error_count, exp_err);
    if (error_count < prev_err) begin
      $display("error_count went down from %0d to %0d at %0t", prev_err, error_count, $time);
      mismatches++;
    end
    if (error_count == '1) begin
      $display("error_count reached its limit at %0t in a short run", $time);
      mismatches++;
    end
    prev_err = error_count;
    if (tb_h == H_TOTAL - 1) begin
      tb_h = 0;
      tb_v = (tb_v == V_TOTAL - 1) ? 0 : tb_v + 1;
    end else begin
      tb_h = tb_h + 1;
    end
  endtask

  task automatic run_row(input int idx);
    test_row_t row;
    int        fails_before;
    int        cycles;
    row          = table_rows[idx];
    fails_before = mismatches;
    apply_reset(row.pat, row.cw);
    cycles = row.frames * H_TOTAL * V_TOTAL;  // Whole frames
    for (int c = 0; c < cycles; c++) begin
      run_cycle(row.pat, row.cw);
    end
    check_errors("final error_count", error_count, row.exp_errors);
    if (mismatches == fails_before) begin
      tests_passed++;
      $display("Test %0d %s cw=%0b frames=%0d: ok", idx, row.pat.name(), row.cw, row.frames);
    end else begin
      tests_failed++;
      $display("Test %0d %s cw=%0b frames=%0d: %0d errors", idx, row.pat.name(), row.cw,
               row.frames, mismatches - fails_before);
    end
  endtask

  initial begin
    rst_n            = 1'b0;
    continuous_write = 1'b0;
    pattern_sel      = PAT_BARS;
    mismatches       = 0;
    tests_passed     = 0;
    tests_failed     = 0;
    table_rows[0] = '{PAT_BARS,     1'b1, 2, error_count_t'(0)};
    table_rows[1] = '{PAT_CHECKER,  1'b1, 2, error_count_t'(0)};
    table_rows[2] = '{PAT_GRADIENT, 1'b1, 2, error_count_t'(0)};
    table_rows[3] = '{PAT_BARS,     1'b0, 2, error_count_t'(2 * VIS_PER_FRAME)};
    table_rows[4] = '{PAT_CHECKER,  1'b0, 4, error_count_t'(4 * VIS_PER_FRAME)};  // Long starve
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    $display("Tests %0d, passed %0d, failed %0d, errors %0d", NUM_ROWS, tests_passed,
             tests_failed, mismatches);
    if ((mismatches == 0) && (tests_failed == 0)) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
verilog/vga_timing_pkg.sv
verilog/gfx_pkg.sv
verilog/gfx_pattern_gen.sv
verilog/gfx_pixel_fifo.sv
verilog/vga_timing.sv
verilog/vga_pixel_out.sv
verilog/gfx_pattern_demo_top.sv
verif/tb_clock_gen.sv
verif/gfx_pattern_demo_tb.sv

// ==== Makefile ====
TOP = gfx_pattern_demo_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f files.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module gfx_pattern_demo_top

clean:
	rm -rf obj_dir sim.log
